// ==== common/rs_pkg.sv ====
`default_nettype none

package rs_pkg;

  // lanes fed by the reservation station
  localparam int NUM_LANES = 2;

  // sources per uop, rs1 and rs2
  localparam int NUM_SRCS = 2;

  // stages a tag stays visible for wakeup
  localparam int BCAST_DEPTH = 3;

  // physical register file index width
  localparam int PRF_SIZE_CLOG = 6;
  localparam int ROBID_LEN     = 5;

  typedef logic [PRF_SIZE_CLOG-1:0] pdst_t;
  typedef logic [ROBID_LEN-1:0]     robid_t;
  typedef logic [3:0]               alu_ctrl_t;
  typedef logic                     lane_sel_t;

  // lane ids, also the index into per-lane arrays
  localparam lane_sel_t LANE_ALU = 1'b0;
  localparam lane_sel_t LANE_MUL = 1'b1;

  // uop as it arrives from rename
  typedef struct packed {
    lane_sel_t                   lane;
    robid_t                      robid;
    pdst_t                       pdst;
    alu_ctrl_t                   alu_ctrl;
    pdst_t [NUM_SRCS-1:0]        src;
    // set by the issuer when the producer already wrote back
    logic  [NUM_SRCS-1:0]        src_rdy;
  } uop_t;

  // uop leaving an entry toward the execution lane
  typedef struct packed {
    logic                        v;
    robid_t                      robid;
    alu_ctrl_t                   alu_ctrl;
    pdst_t                       pdst;
    pdst_t [NUM_SRCS-1:0]        src;
  } lane_info_t;

  // one slot of the wakeup window
  typedef struct packed {
    logic  v;
    pdst_t pdst;
  } tag_bcast_t;

endpackage

`default_nettype wire

// ==== verilog/stage_pipe.sv ====
`default_nettype none

module stage_pipe #(
  parameter type T     = logic,
  parameter int  DEPTH = 1
) (
  input  logic clk_free_master,
  input  logic arst_n,
  input  logic in_val,
  input  T     in_data,
  output logic out_val,
  output T     out_data
);

  logic [DEPTH-1:0] val_q;
  T                 data_q [DEPTH];

  // valid chain, cleared on reset
  always_ff @(posedge clk_free_master or negedge arst_n) begin
    if (!arst_n) begin
      val_q <= '0;
    end else begin
      val_q[0] <= in_val;
      for (int i = 1; i < DEPTH; i++) begin
        val_q[i] <= val_q[i-1];
      end
    end
  end

  // payload follows the valid chain
  always_ff @(posedge clk_free_master) begin
    data_q[0] <= in_data;
    for (int i = 1; i < DEPTH; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign out_val  = val_q[DEPTH-1];
  assign out_data = data_q[DEPTH-1];

  // output valid is the input valid exactly DEPTH edges late
  a_val_latency: assert property (@(posedge clk_free_master) disable iff (!arst_n)
    $past(arst_n, DEPTH) |-> (out_val == $past(in_val, DEPTH)));

endmodule

`default_nettype wire

// ==== rs_lane/rs_wakeup.sv ====
`default_nettype none

module rs_wakeup #(
  parameter int RS_NUM_ENTRIES = 4
) (
  input  logic                                                   clk_free_master,
  input  logic                                                   arst_n,
  input  logic [RS_NUM_ENTRIES-1:0]                              ety_valid,
  input  rs_pkg::pdst_t [RS_NUM_ENTRIES-1:0][rs_pkg::NUM_SRCS-1:0] ety_src,
  input  logic [RS_NUM_ENTRIES-1:0]                              alloc_oh,
  input  logic [rs_pkg::NUM_SRCS-1:0]                            alloc_src_rdy,
  input  rs_pkg::pdst_t [rs_pkg::NUM_SRCS-1:0]                   alloc_src,
  input  logic [RS_NUM_ENTRIES-1:0]                              free_oh,
  input  rs_pkg::tag_bcast_t [rs_pkg::BCAST_DEPTH-1:0][rs_pkg::NUM_LANES-1:0] bcast,
  output logic [RS_NUM_ENTRIES-1:0]                              ety_rdy
);

  import rs_pkg::*;

  logic [RS_NUM_ENTRIES-1:0][NUM_SRCS-1:0] src_rdy_q;
  logic [RS_NUM_ENTRIES-1:0][NUM_SRCS-1:0] src_rdy_nxt;
  logic [RS_NUM_ENTRIES-1:0][NUM_SRCS-1:0] src_rdy_d;
  logic [NUM_SRCS-1:0]                     alloc_rdy;

  // any valid slot in the window carrying this tag
  function automatic logic tag_hit(
    input pdst_t                                     tag,
    input tag_bcast_t [BCAST_DEPTH-1:0][NUM_LANES-1:0] win
  );
    logic hit;
    hit = 1'b0;
    for (int s = 0; s < BCAST_DEPTH; s++) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        hit |= win[s][l].v && (win[s][l].pdst == tag);
      end
    end
    return hit;
  endfunction

  always_comb begin
    // new uop also sees tags already in flight
    for (int s = 0; s < NUM_SRCS; s++) begin
      alloc_rdy[s] = alloc_src_rdy[s] | tag_hit(alloc_src[s], bcast);
    end
    for (int e = 0; e < RS_NUM_ENTRIES; e++) begin
      for (int s = 0; s < NUM_SRCS; s++) begin
        src_rdy_nxt[e][s] = src_rdy_q[e][s] | tag_hit(ety_src[e][s], bcast);
      end
      // same-cycle wakeup feeds the pick directly
      ety_rdy[e] = ety_valid[e] & (&src_rdy_nxt[e]);
      if (free_oh[e]) begin
        src_rdy_d[e] = '0;
      end else if (alloc_oh[e]) begin
        src_rdy_d[e] = alloc_rdy;
      end else if (ety_valid[e]) begin
        src_rdy_d[e] = src_rdy_nxt[e];
      end else begin
        src_rdy_d[e] = '0;
      end
    end
  end

  // sticky until the entry is freed
  always_ff @(posedge clk_free_master or negedge arst_n) begin
    if (!arst_n) begin
      src_rdy_q <= '0;
    end else begin
      src_rdy_q <= src_rdy_d;
    end
  end

  // allocation picks a free entry, dispatch a valid one
  a_alloc_free_disjoint: assert property (@(posedge clk_free_master) disable iff (!arst_n)
    (alloc_oh & free_oh) == '0);

endmodule

`default_nettype wire

// ==== rs_lane/rs_lane.sv ====
`default_nettype none

module rs_lane #(
  parameter int                RS_NUM_ENTRIES = 4,
  parameter rs_pkg::lane_sel_t LANE_ID        = rs_pkg::LANE_ALU
) (
  input  logic                                clk_free_master,
  input  logic                                arst_n,
  input  logic                                issue_val,
  input  rs_pkg::uop_t                        issue_uop,
  input  rs_pkg::tag_bcast_t [rs_pkg::BCAST_DEPTH-1:0][rs_pkg::NUM_LANES-1:0] bcast,
  output rs_pkg::lane_info_t                  disp_irf,
  output rs_pkg::lane_info_t                  lane_info_ex1,
  output logic                                rs_full,
  output logic [$clog2(RS_NUM_ENTRIES+1)-1:0] rs_count
);

  import rs_pkg::*;

  uop_t  [RS_NUM_ENTRIES-1:0]               ety_uop;
  logic  [RS_NUM_ENTRIES-1:0]               ety_valid;
  pdst_t [RS_NUM_ENTRIES-1:0][NUM_SRCS-1:0] ety_src;
  logic  [RS_NUM_ENTRIES-1:0]               free_vec;
  logic  [RS_NUM_ENTRIES-1:0]               alloc_oh;
  logic  [RS_NUM_ENTRIES-1:0]               ety_rdy;
  logic  [RS_NUM_ENTRIES-1:0]               pick_oh;
  logic                                     issue_hit;
  logic                                     disp_v_q;
  lane_info_t                               disp_data_d;
  lane_info_t                               disp_data_q;
  logic                                     ex1_val;
  lane_info_t                               ex1_data;

  // uop is steered here only when its lane field matches
  assign issue_hit = issue_val && (issue_uop.lane == LANE_ID);

  // lowest free entry, isolate lowest set bit
  assign free_vec = ~ety_valid;
  assign alloc_oh = issue_hit ? (free_vec & (~free_vec + 1'b1)) : '0;

  // lowest ready entry wins, no age ordering
  assign pick_oh = ety_rdy & (~ety_rdy + 1'b1);

  always_ff @(posedge clk_free_master or negedge arst_n) begin
    if (!arst_n) begin
      ety_valid <= '0;
    end else begin
      // picked entry leaves, new uop lands
      ety_valid <= (ety_valid & ~pick_oh) | alloc_oh;
    end
  end

  // entry payload written only on allocation
  always_ff @(posedge clk_free_master) begin
    for (int e = 0; e < RS_NUM_ENTRIES; e++) begin
      if (alloc_oh[e]) begin
        ety_uop[e] <= issue_uop;
      end
    end
  end

  always_comb begin
    rs_count = '0;
    for (int e = 0; e < RS_NUM_ENTRIES; e++) begin
      rs_count = rs_count + ety_valid[e];
      ety_src[e] = ety_uop[e].src;
    end
  end

  assign rs_full = &ety_valid;

  rs_wakeup #(
    .RS_NUM_ENTRIES (RS_NUM_ENTRIES)
  ) u_wakeup (
    .clk_free_master (clk_free_master),
    .arst_n          (arst_n),
    .ety_valid       (ety_valid),
    .ety_src         (ety_src),
    .alloc_oh        (alloc_oh),
    .alloc_src_rdy   (issue_uop.src_rdy),
    .alloc_src       (issue_uop.src),
    .free_oh         (pick_oh),
    .bcast           (bcast),
    .ety_rdy         (ety_rdy)
  );

  // one-hot mux of the picked entry
  always_comb begin
    disp_data_d = '0;
    for (int e = 0; e < RS_NUM_ENTRIES; e++) begin
      if (pick_oh[e]) begin
        disp_data_d.robid    = ety_uop[e].robid;
        disp_data_d.alu_ctrl = ety_uop[e].alu_ctrl;
        disp_data_d.pdst     = ety_uop[e].pdst;
        disp_data_d.src      = ety_uop[e].src;
      end
    end
  end

  // irf stage
  always_ff @(posedge clk_free_master or negedge arst_n) begin
    if (!arst_n) begin
      disp_v_q <= 1'b0;
    end else begin
      disp_v_q <= |pick_oh;
    end
  end

  always_ff @(posedge clk_free_master) begin
    disp_data_q <= disp_data_d;
  end

  always_comb begin
    disp_irf   = disp_data_q;
    disp_irf.v = disp_v_q;
  end

  // irf -> fwd -> ex1
  stage_pipe #(
    .T     (lane_info_t),
    .DEPTH (2)
  ) u_irf_to_ex1 (
    .clk_free_master (clk_free_master),
    .arst_n          (arst_n),
    .in_val          (disp_irf.v),
    .in_data         (disp_irf),
    .out_val         (ex1_val),
    .out_data        (ex1_data)
  );

  always_comb begin
    lane_info_ex1   = ex1_data;
    lane_info_ex1.v = ex1_val;
  end

  // at most one pick, and only from a live entry
  a_pick_onehot: assert property (@(posedge clk_free_master) disable iff (!arst_n)
    $onehot0(pick_oh) && ((pick_oh & ~ety_valid) == '0));

  // the issuer owns back-pressure, a uop sent while full is dropped
  a_no_issue_full: assert property (@(posedge clk_free_master) disable iff (!arst_n)
    issue_hit |-> !rs_full);

endmodule

`default_nettype wire

// ==== verilog/tag_broadcast.sv ====
`default_nettype none

module tag_broadcast (
  input  logic               clk_free_master,
  input  logic               arst_n,
  input  rs_pkg::lane_info_t disp_alu,
  input  rs_pkg::lane_info_t disp_mul,
  output rs_pkg::tag_bcast_t [rs_pkg::BCAST_DEPTH-1:0][rs_pkg::NUM_LANES-1:0] bcast
);

  import rs_pkg::*;

  logic                                   mul_v;
  pdst_t                                  mul_pdst;
  tag_bcast_t [NUM_LANES-1:0]             win_s0;
  logic       [BCAST_DEPTH-1:1][NUM_LANES-1:0] win_v_q;
  pdst_t      [BCAST_DEPTH-1:1][NUM_LANES-1:0] win_pdst_q;
  tag_bcast_t [BCAST_DEPTH*NUM_LANES-1:0] win_flat;
  logic                                   dup_tag;

  // mul result lands a cycle later, so its tag does too
  stage_pipe #(
    .T     (pdst_t),
    .DEPTH (1)
  ) u_mul_dly (
    .clk_free_master (clk_free_master),
    .arst_n          (arst_n),
    .in_val          (disp_mul.v),
    .in_data         (disp_mul.pdst),
    .out_val         (mul_v),
    .out_data        (mul_pdst)
  );

  // stage 0, alu tag straight from irf
  always_comb begin
    win_s0[LANE_ALU].v    = disp_alu.v;
    win_s0[LANE_ALU].pdst = disp_alu.pdst;
    win_s0[LANE_MUL].v    = mul_v;
    win_s0[LANE_MUL].pdst = mul_pdst;
  end

  always_ff @(posedge clk_free_master or negedge arst_n) begin
    if (!arst_n) begin
      win_v_q <= '0;
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        win_v_q[1][l] <= win_s0[l].v;
      end
      for (int s = 2; s < BCAST_DEPTH; s++) begin
        win_v_q[s] <= win_v_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_free_master) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      win_pdst_q[1][l] <= win_s0[l].pdst;
    end
    for (int s = 2; s < BCAST_DEPTH; s++) begin
      win_pdst_q[s] <= win_pdst_q[s-1];
    end
  end

  always_comb begin
    bcast[0] = win_s0;
    for (int s = 1; s < BCAST_DEPTH; s++) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        bcast[s][l].v    = win_v_q[s][l];
        bcast[s][l].pdst = win_pdst_q[s][l];
      end
    end
  end

  // pairwise tag compare over the whole window
  assign win_flat = bcast;

  always_comb begin
    dup_tag = 1'b0;
    for (int i = 0; i < BCAST_DEPTH*NUM_LANES; i++) begin
      for (int j = i + 1; j < BCAST_DEPTH*NUM_LANES; j++) begin
        if (win_flat[i].v && win_flat[j].v && (win_flat[i].pdst == win_flat[j].pdst)) begin
          dup_tag = 1'b1;
        end
      end
    end
  end

  // a pdst is owned by one uop while in flight
  a_unique_tags: assert property (@(posedge clk_free_master) disable iff (!arst_n)
    !dup_tag);

endmodule

`default_nettype wire

// ==== verilog/rs_top.sv ====
`default_nettype none

module rs_top #(
  parameter int RS_NUM_ENTRIES = 4
) (
  input  logic                                                    clk_free_master,
  input  logic                                                    arst_n,
  input  logic                                                    issue_val,
  input  rs_pkg::uop_t                                            issue_uop,
  output rs_pkg::lane_info_t [rs_pkg::NUM_LANES-1:0]              lane_info_ex1,
  output logic [rs_pkg::NUM_LANES-1:0]                            rs_full,
  output logic [rs_pkg::NUM_LANES-1:0][$clog2(RS_NUM_ENTRIES+1)-1:0] rs_count
);

  import rs_pkg::*;

  lane_info_t [NUM_LANES-1:0]                  disp_irf;
  tag_bcast_t [BCAST_DEPTH-1:0][NUM_LANES-1:0] bcast;

  // supported entry counts
  if (RS_NUM_ENTRIES < 2 || RS_NUM_ENTRIES > 16) begin : g_bad_cfg
    $error("rs_top: RS_NUM_ENTRIES must be 2..16");
  end

  // lane index doubles as LANE_ID, alu is 0 and mul is 1
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    rs_lane #(
      .RS_NUM_ENTRIES (RS_NUM_ENTRIES),
      .LANE_ID        (lane_sel_t'(g))
    ) u_lane (
      .clk_free_master (clk_free_master),
      .arst_n          (arst_n),
      // issue fans out, each lane filters on its id
      .issue_val       (issue_val),
      .issue_uop       (issue_uop),
      .bcast           (bcast),
      .disp_irf        (disp_irf[g]),
      .lane_info_ex1   (lane_info_ex1[g]),
      .rs_full         (rs_full[g]),
      .rs_count        (rs_count[g])
    );
  end

  // both lanes wake up from the same window
  tag_broadcast u_tag_broadcast (
    .clk_free_master (clk_free_master),
    .arst_n          (arst_n),
    .disp_alu        (disp_irf[LANE_ALU]),
    .disp_mul        (disp_irf[LANE_MUL]),
    .bcast           (bcast)
  );

endmodule

`default_nettype wire

// ==== verif/rs_tb.sv ====
`default_nettype none

module rs_tb;

  import rs_pkg::*;

  localparam int RS_N         = 4;
  localparam int CNT_W        = $clog2(RS_N + 1);
  localparam int ISSUE_TO_EX1 = 3;
  // roughly 150 cycles of directed and random traffic, plenty of margin
  localparam int MAX_CYCLES   = 400;
  localparam int NUM_RANDOM   = 32;

  // one expected ex1 result plus its timing rule
  typedef struct packed {
    lane_info_t  info;
    logic [31:0] issue_cyc;
    logic        lat_chk;
    robid_t      dep_robid;
    logic [1:0]  dep_gap;
  } exp_t;

  logic                                  clk_free_master;
  logic                                  arst_n;
  logic                                  issue_val;
  uop_t                                  issue_uop;
  lane_info_t [NUM_LANES-1:0]            lane_info_ex1;
  logic       [NUM_LANES-1:0]            rs_full;
  logic       [NUM_LANES-1:0][CNT_W-1:0] rs_count;

  // side info travelling with each issue
  logic       drv_lat_chk;
  robid_t     drv_dep_robid;
  logic [1:0] drv_dep_gap;
  logic       fill_chk;

  // per-lane expected queues
  exp_t                       exp_mem [NUM_LANES][16];
  logic [NUM_LANES-1:0][3:0]  wr_ptr;
  logic [NUM_LANES-1:0][3:0]  rd_ptr;
  logic [NUM_LANES-1:0][3:0]  exp_cnt;
  exp_t [NUM_LANES-1:0]       exp_head;
  int                         want_cyc [NUM_LANES];
  int                         ex1_seen [2**ROBID_LEN];
  int                         cyc = 0;

  integer seed;
  robid_t next_robid;
  pdst_t  next_pdst;
  robid_t last_robid;

  rs_top #(
    .RS_NUM_ENTRIES (RS_N)
  ) dut (
    .clk_free_master (clk_free_master),
    .arst_n          (arst_n),
    .issue_val       (issue_val),
    .issue_uop       (issue_uop),
    .lane_info_ex1   (lane_info_ex1),
    .rs_full         (rs_full),
    .rs_count        (rs_count)
  );

  initial begin
    clk_free_master = 1'b0;
    forever #2 clk_free_master = ~clk_free_master;
  end

  task automatic fail_run(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  always @(posedge clk_free_master) begin
    cyc <= cyc + 1;
    if (cyc == MAX_CYCLES) begin
      fail_run("timeout, uops did not drain within the cycle limit");
    end
  end

  // push on the issue edge, pop when ex1 shows up
  always @(posedge clk_free_master or negedge arst_n) begin
    exp_t e;
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (issue_val) begin
        e.info.v        = 1'b1;
        e.info.robid    = issue_uop.robid;
        e.info.alu_ctrl = issue_uop.alu_ctrl;
        e.info.pdst     = issue_uop.pdst;
        e.info.src      = issue_uop.src;
        e.issue_cyc     = cyc;
        e.lat_chk       = drv_lat_chk;
        e.dep_robid     = drv_dep_robid;
        e.dep_gap       = drv_dep_gap;
        exp_mem[issue_uop.lane][wr_ptr[issue_uop.lane]] <= e;
        wr_ptr[issue_uop.lane] <= wr_ptr[issue_uop.lane] + 1'b1;
      end
      for (int l = 0; l < NUM_LANES; l++) begin
        if (lane_info_ex1[l].v) begin
          rd_ptr[l] <= rd_ptr[l] + 1'b1;
          ex1_seen[lane_info_ex1[l].robid] <= cyc;
        end
      end
    end
  end

  // ex1 is seen one edge after the edge that launched it
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      if (exp_head[l].lat_chk) begin
        want_cyc[l] = exp_head[l].issue_cyc + ISSUE_TO_EX1 + 1;
      end else if (exp_head[l].dep_gap != 0) begin
        want_cyc[l] = ex1_seen[exp_head[l].dep_robid] + exp_head[l].dep_gap;
      end else begin
        want_cyc[l] = 0;
      end
    end
  end

  a_reset_state: assert property (@(posedge clk_free_master)
    $rose(arst_n) |-> (rs_count == '0) && (rs_full == '0) &&
      !lane_info_ex1[LANE_ALU].v && !lane_info_ex1[LANE_MUL].v)
    else fail_run("lane state not cleared after reset");

  // filling the alu lane, nothing dispatches there
  a_fill_step: assert property (@(posedge clk_free_master) disable iff (!arst_n)
    fill_chk && issue_val && (issue_uop.lane == LANE_ALU) |=>
      rs_count[LANE_ALU] == $past(rs_count[LANE_ALU]) + 1'b1)
    else fail_run($sformatf("alu rs_count %0d did not step up",
      $sampled(rs_count[LANE_ALU])));

  for (genvar l = 0; l < NUM_LANES; l++) begin : g_chk
    assign exp_cnt[l]  = wr_ptr[l] - rd_ptr[l];
    assign exp_head[l] = exp_mem[l][rd_ptr[l]];

    a_full_flag: assert property (@(posedge clk_free_master) disable iff (!arst_n)
      rs_full[l] == (rs_count[l] == RS_N))
      else fail_run($sformatf("lane %0d rs_full %0b with rs_count %0d", l,
        $sampled(rs_full[l]), $sampled(rs_count[l])));

    a_ex1_expected: assert property (@(posedge clk_free_master) disable iff (!arst_n)
      lane_info_ex1[l].v |-> exp_cnt[l] != 0)
      else fail_run($sformatf("lane %0d ex1 robid %0d was never issued to it", l,
        $sampled(lane_info_ex1[l].robid)));

    a_ex1_fields: assert property (@(posedge clk_free_master) disable iff (!arst_n)
      lane_info_ex1[l].v |-> lane_info_ex1[l] == exp_head[l].info)
      else fail_run($sformatf("lane %0d ex1 robid %0d pdst %0d, expected robid %0d pdst %0d",
        l, $sampled(lane_info_ex1[l].robid), $sampled(lane_info_ex1[l].pdst),
        $sampled(exp_head[l].info.robid), $sampled(exp_head[l].info.pdst)));

    a_ex1_timing: assert property (@(posedge clk_free_master) disable iff (!arst_n)
      lane_info_ex1[l].v |-> (want_cyc[l] == 0) || (cyc == want_cyc[l]))
      else fail_run($sformatf("lane %0d ex1 robid %0d at cycle %0d, expected cycle %0d", l,
        $sampled(lane_info_ex1[l].robid), $sampled(cyc), $sampled(want_cyc[l])));
  end

  function automatic pdst_t new_tag();
    new_tag   = next_pdst;
    next_pdst = next_pdst + 1'b1;
  endfunction

  // src1 is random, rdy bit 1 usually set
  task automatic send_uop(input lane_sel_t lane, input pdst_t pdst, input pdst_t src0,
                          input logic [1:0] rdy, input logic lat_chk,
                          input robid_t dep, input logic [1:0] gap);
    uop_t u;
    @(posedge clk_free_master);
    u.lane     = lane;
    u.robid    = next_robid;
    u.pdst     = pdst;
    u.alu_ctrl = alu_ctrl_t'($random(seed));
    u.src[0]   = src0;
    u.src[1]   = pdst_t'($random(seed));
    u.src_rdy  = rdy;
    issue_val     <= 1'b1;
    issue_uop     <= u;
    drv_lat_chk   <= lat_chk;
    drv_dep_robid <= dep;
    drv_dep_gap   <= gap;
    fill_chk      <= 1'b0;
    last_robid = next_robid;
    next_robid = next_robid + 1'b1;
  endtask

  task automatic idle_cycle();
    @(posedge clk_free_master);
    issue_val <= 1'b0;
    fill_chk  <= 1'b0;
  endtask

  task automatic wait_drain();
    do @(posedge clk_free_master); while (exp_cnt[0] != 0 || exp_cnt[1] != 0);
    assert (rs_count == '0) else fail_run("rs_count not back to 0 after all uops left");
  endtask

  initial begin
    int     r;
    pdst_t  x;
    pdst_t  p;
    robid_t prod;
    pdst_t  tags [RS_N];
    seed          = 32'h1e15_a23f;
    next_robid    = '0;
    next_pdst     = 6'd1;
    arst_n        = 1'b0;
    issue_val     = 1'b0;
    issue_uop     = '0;
    drv_lat_chk   = 1'b0;
    drv_dep_robid = '0;
    drv_dep_gap   = '0;
    fill_chk      = 1'b0;
    repeat (2) @(posedge clk_free_master);
    arst_n <= 1'b1;
    idle_cycle();

    // single ready uop into each empty lane
    for (int l = 0; l < NUM_LANES; l++) begin
      send_uop(lane_sel_t'(l), new_tag(), new_tag(), 2'b11, 1'b1, '0, 2'd0);
      idle_cycle();
      wait_drain();
    end

    // fill alu lane on tags nobody produces yet
    for (int i = 0; i < RS_N; i++) begin
      tags[i] = new_tag();
      send_uop(LANE_ALU, new_tag(), tags[i], 2'b10, 1'b0, '0, 2'd0);
      fill_chk <= 1'b1;
    end
    // mul producers release them in entry order
    for (int i = 0; i < RS_N; i++) begin
      send_uop(LANE_MUL, tags[i], new_tag(), 2'b11, 1'b1, '0, 2'd0);
    end
    idle_cycle();
    wait_drain();

    // alu producer waits on a mul trigger, dependent one cycle behind
    x = new_tag();
    p = new_tag();
    send_uop(LANE_ALU, p, x, 2'b10, 1'b0, '0, 2'd0);
    prod = last_robid;
    send_uop(LANE_MUL, x, new_tag(), 2'b11, 1'b1, '0, 2'd0);
    send_uop(LANE_ALU, new_tag(), p, 2'b10, 1'b0, prod, 2'd1);
    idle_cycle();
    wait_drain();

    // mul producer, dependent two cycles behind
    x = new_tag();
    p = new_tag();
    send_uop(LANE_MUL, p, x, 2'b10, 1'b0, '0, 2'd0);
    prod = last_robid;
    send_uop(LANE_ALU, x, new_tag(), 2'b11, 1'b1, '0, 2'd0);
    send_uop(LANE_ALU, new_tag(), p, 2'b10, 1'b0, prod, 2'd2);
    idle_cycle();
    wait_drain();

    // random ready stream, two issues may still be in flight
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r = $random(seed);
      if (r[1:0] != 2'b00 && rs_count[r[8]] < RS_N - 2) begin
        send_uop(lane_sel_t'(r[8]), new_tag(), new_tag(), 2'b11, 1'b1, '0, 2'd0);
      end else begin
        idle_cycle();
      end
    end
    idle_cycle();
    wait_drain();

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/rs_pkg.sv
verilog/stage_pipe.sv
rs_lane/rs_wakeup.sv
rs_lane/rs_lane.sv
verilog/tag_broadcast.sv
verilog/rs_top.sv
verif/rs_tb.sv
